//--- hdl/vec_pkg.sv
`default_nettype none

package vec_pkg;

    // phit geometry
    localparam int LANES  = 4;
    localparam int ELEM_W = 32;
    localparam int PHIT_W = LANES * ELEM_W;

    // vector register file
    localparam int VRF_DEPTH = 16;
    localparam int ADDR_W    = 4;
    localparam int LEN_W     = 5; // 1 to 16 entries

    localparam int FIFO_DEPTH_DEFAULT = 16;

    typedef enum logic [2:0] {
        OP_NOP        = 3'd0,
        OP_VSTREAMIN  = 3'd1, // stream phits into vd
        OP_VCLR       = 3'd2, // vmv.v.i with zero
        OP_VMACC      = 3'd3, // vd += stream * vs
        OP_VSTREAMOUT = 3'd4, // vs out to the stream
        OP_VEND       = 3'd5
    } opcode_e;

    typedef enum logic [2:0] {
        ST_OFF   = 3'd0,
        ST_FETCH = 3'd1,
        ST_RUN   = 3'd2,
        ST_DRAIN = 3'd3,
        ST_DONE  = 3'd4
    } seq_state_e;

endpackage

`default_nettype wire

//--- hdl/stream_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module stream_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 16
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             i_push,
    input  logic             i_pop,
    input  logic [WIDTH-1:0] i_din,
    output logic [WIDTH-1:0] o_dout,
    output logic             o_empty,
    output logic             o_full
);

    localparam int AW = $clog2(DEPTH);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [AW:0]      count;
    logic             push_ok;
    logic             pop_ok;

    assign push_ok = i_push && !o_full; // dropped when full
    assign pop_ok  = i_pop && !o_empty;

    assign o_empty = (count == '0);
    assign o_full  = (count == DEPTH[AW:0]);
    assign o_dout  = mem[rd_ptr]; // first word falls through

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop_ok)
                rd_ptr <= rd_ptr + 1'b1;
            if (push_ok && !pop_ok)
                count <= count + 1'b1;
            else if (pop_ok && !push_ok)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push_ok)
            mem[wr_ptr] <= i_din;
    end

endmodule

`default_nettype wire

//--- hdl/vec_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module vec_regfile (
    input  logic                        clk,
    input  logic                        i_we,
    input  logic [vec_pkg::ADDR_W-1:0]  i_wr_addr,
    input  logic [vec_pkg::PHIT_W-1:0]  i_wr_data,
    input  logic [vec_pkg::ADDR_W-1:0]  i_rd_addr1,
    input  logic [vec_pkg::ADDR_W-1:0]  i_rd_addr2,
    input  logic                        i_rd_en,
    output logic [vec_pkg::PHIT_W-1:0]  o_rd_data1,
    output logic [vec_pkg::PHIT_W-1:0]  o_rd_data2
);

    logic [vec_pkg::PHIT_W-1:0] mem [vec_pkg::VRF_DEPTH];

    always_ff @(posedge clk) begin
        if (i_we)
            mem[i_wr_addr] <= i_wr_data;
    end

    // read data held while the pipeline is stalled
    always_ff @(posedge clk) begin
        if (i_rd_en) begin
            o_rd_data1 <= mem[i_rd_addr1]; // source / stream out
            o_rd_data2 <= mem[i_rd_addr2]; // accumulator
        end
    end

endmodule

`default_nettype wire

//--- hdl/mac_lanes.sv
`timescale 1ns/1ps
`default_nettype none

module mac_lanes (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        i_en,
    input  logic                        i_valid,
    input  logic [vec_pkg::PHIT_W-1:0]  i_acc,
    input  logic [vec_pkg::PHIT_W-1:0]  i_a,
    input  logic [vec_pkg::PHIT_W-1:0]  i_b,
    output logic [vec_pkg::PHIT_W-1:0]  o_sum,
    output logic                        o_valid
);

    localparam int EW = vec_pkg::ELEM_W;

    always_ff @(posedge clk) begin
        if (rst)
            o_valid <= 1'b0;
        else if (i_en)
            o_valid <= i_valid;
    end

    // wraps at 32 bits per lane
    always_ff @(posedge clk) begin
        if (i_en) begin
            for (int l = 0; l < vec_pkg::LANES; l++) begin
                o_sum[l*EW +: EW] <= i_acc[l*EW +: EW] + i_a[l*EW +: EW] * i_b[l*EW +: EW];
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/element_counter.sv
`timescale 1ns/1ps
`default_nettype none

module element_counter (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        i_start,
    input  logic [vec_pkg::LEN_W-1:0]   i_len,
    input  logic [vec_pkg::ADDR_W-1:0]  i_rd_base,
    input  logic [vec_pkg::ADDR_W-1:0]  i_wr_base,
    input  logic                        i_stall,
    output logic [vec_pkg::ADDR_W-1:0]  o_rd_addr,
    output logic [vec_pkg::ADDR_W-1:0]  o_wr_addr,
    output logic                        o_issuing,
    output logic                        o_last_issue,
    output logic                        o_pipe_busy
);

    logic [vec_pkg::LEN_W-1:0] remaining;
    logic                      v1;  // element in read stage
    logic                      v2;  // element in mac / output stage

    assign o_issuing    = (remaining != '0);
    assign o_last_issue = (remaining == 1);
    assign o_pipe_busy  = v1 || v2;

    always_ff @(posedge clk) begin
        if (rst) begin
            remaining <= '0;
            v1        <= 1'b0;
            v2        <= 1'b0;
            o_rd_addr <= '0;
            o_wr_addr <= '0;
        end else if (i_start) begin
            remaining <= i_len;
            v1        <= 1'b0;
            v2        <= 1'b0;
            o_rd_addr <= i_rd_base;
            o_wr_addr <= i_wr_base;
        end else if (!i_stall) begin
            v1 <= o_issuing;
            v2 <= v1;
            if (o_issuing) begin
                remaining <= remaining - 1'b1;
                o_rd_addr <= o_rd_addr + 1'b1;
            end
            // write side advances as results leave stage two
            if (v2)
                o_wr_addr <= o_wr_addr + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- hdl/vec_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module vec_sequencer (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        i_done_loader,
    input  vec_pkg::opcode_e            i_instr_op,
    input  logic [vec_pkg::ADDR_W-1:0]  i_instr_vd,
    input  logic [vec_pkg::ADDR_W-1:0]  i_instr_vs,
    input  logic [vec_pkg::LEN_W-1:0]   i_instr_len,
    input  logic                        i_in_empty,
    input  logic                        i_out_full,
    input  logic                        i_issuing,
    input  logic                        i_pipe_busy,
    output logic                        o_start,
    output logic [vec_pkg::LEN_W-1:0]   o_len,
    output logic [vec_pkg::ADDR_W-1:0]  o_rd_base,
    output logic [vec_pkg::ADDR_W-1:0]  o_wr_base,
    output vec_pkg::opcode_e            o_active_op,
    output logic                        o_stall,
    output logic                        o_done_steady,
    output logic                        o_incr_pc,
    output logic                        o_ap_done
);

    vec_pkg::seq_state_e state, state_nxt;
    logic                elem_op;
    logic                reads_vs;
    logic                running;

    assign elem_op  = (i_instr_op == vec_pkg::OP_VSTREAMIN) || (i_instr_op == vec_pkg::OP_VCLR) ||
                      (i_instr_op == vec_pkg::OP_VMACC) || (i_instr_op == vec_pkg::OP_VSTREAMOUT);
    assign reads_vs = (i_instr_op == vec_pkg::OP_VMACC) || (i_instr_op == vec_pkg::OP_VSTREAMOUT);

    // counter start, straight from the held instruction
    assign o_start   = (state == vec_pkg::ST_FETCH) && elem_op;
    assign o_len     = i_instr_len;
    assign o_rd_base = reads_vs ? i_instr_vs : i_instr_vd;
    assign o_wr_base = i_instr_vd;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= vec_pkg::ST_OFF;
            o_active_op <= vec_pkg::OP_NOP;
        end else begin
            state <= state_nxt;
            if (state == vec_pkg::ST_FETCH)
                o_active_op <= i_instr_op; // latched for the whole run
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            vec_pkg::ST_OFF:   if (i_done_loader) state_nxt = vec_pkg::ST_FETCH;
            vec_pkg::ST_FETCH: state_nxt = elem_op ? vec_pkg::ST_RUN : vec_pkg::ST_DONE;
            vec_pkg::ST_RUN:   if (!i_issuing) state_nxt = vec_pkg::ST_DRAIN;
            vec_pkg::ST_DRAIN: if (!i_pipe_busy) state_nxt = vec_pkg::ST_DONE;
            vec_pkg::ST_DONE:  state_nxt = o_ap_done ? vec_pkg::ST_OFF : vec_pkg::ST_FETCH;
            default:           state_nxt = vec_pkg::ST_OFF;
        endcase
    end

    // stall only matters while elements move
    assign running = (state == vec_pkg::ST_RUN) || (state == vec_pkg::ST_DRAIN);

    always_comb begin
        case (o_active_op)
            vec_pkg::OP_VSTREAMIN,
            vec_pkg::OP_VMACC:      o_stall = running && i_issuing && i_in_empty; // starved
            vec_pkg::OP_VSTREAMOUT: o_stall = running && i_out_full; // back-pressure
            default:                o_stall = 1'b0;
        endcase
    end

    assign o_done_steady = (state != vec_pkg::ST_OFF);
    assign o_incr_pc     = (state == vec_pkg::ST_DONE);
    assign o_ap_done     = (state == vec_pkg::ST_DONE) && (o_active_op == vec_pkg::OP_VEND);

endmodule

`default_nettype wire

//--- hdl/vec_stream_top.sv
`timescale 1ns/1ps
`default_nettype none

module vec_stream_top #(
    parameter int FIFO_DEPTH = vec_pkg::FIFO_DEPTH_DEFAULT
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          i_done_loader,
    input  vec_pkg::opcode_e              i_instr_op,
    input  logic [vec_pkg::ADDR_W-1:0]    i_instr_vd,
    input  logic [vec_pkg::ADDR_W-1:0]    i_instr_vs,
    input  logic [vec_pkg::LEN_W-1:0]     i_instr_len,
    input  logic [vec_pkg::PHIT_W-1:0]    i_s_tdata,
    input  logic                          i_s_tvalid,
    output logic                          o_s_tready,
    output logic [vec_pkg::PHIT_W-1:0]    o_m_tdata,
    output logic                          o_m_tvalid,
    output logic                          o_m_tlast,
    output logic [vec_pkg::PHIT_W/8-1:0]  o_m_tkeep,
    input  logic                          i_m_tready,
    output logic                          o_done_steady,
    output logic                          o_incr_pc,
    output logic                          o_ap_done
);

    localparam int PW = vec_pkg::PHIT_W;
    localparam int AW = vec_pkg::ADDR_W;

    logic                      in_push, in_pop, in_empty, in_full;
    logic [PW-1:0]             in_dout;
    logic                      out_push, out_empty, out_full;
    logic [PW:0]               out_din, out_dout; // {tlast, tdata}
    logic                      start, stall, issuing, last_issue, pipe_busy;
    logic [vec_pkg::LEN_W-1:0] len;
    logic [AW-1:0]             rd_base, wr_base, rd_addr, wr_addr, acc_addr, vrf_wr_addr;
    vec_pkg::opcode_e          active_op;
    logic                      vrf_we, uses_input;
    logic [PW-1:0]             vrf_wr_data, rd_data1, rd_data2, mac_sum, in_q, out_q;
    logic                      s1_valid, s1_last, s2_last, mac_valid;

    assign uses_input = (active_op == vec_pkg::OP_VSTREAMIN) || (active_op == vec_pkg::OP_VMACC);
    assign o_s_tready = !in_full && o_done_steady;
    assign in_push    = i_s_tvalid && o_s_tready;
    assign in_pop     = issuing && !stall && uses_input;

    stream_fifo #(.WIDTH(PW), .DEPTH(FIFO_DEPTH)) u_in_fifo (
        .clk(clk), .rst(rst), .i_push(in_push), .i_pop(in_pop), .i_din(i_s_tdata),
        .o_dout(in_dout), .o_empty(in_empty), .o_full(in_full)
    );

    vec_sequencer u_sequencer (
        .clk(clk), .rst(rst), .i_done_loader(i_done_loader), .i_instr_op(i_instr_op),
        .i_instr_vd(i_instr_vd), .i_instr_vs(i_instr_vs), .i_instr_len(i_instr_len),
        .i_in_empty(in_empty), .i_out_full(out_full), .i_issuing(issuing),
        .i_pipe_busy(pipe_busy), .o_start(start), .o_len(len), .o_rd_base(rd_base),
        .o_wr_base(wr_base), .o_active_op(active_op), .o_stall(stall),
        .o_done_steady(o_done_steady), .o_incr_pc(o_incr_pc), .o_ap_done(o_ap_done)
    );

    element_counter u_counter (
        .clk(clk), .rst(rst), .i_start(start), .i_len(len), .i_rd_base(rd_base),
        .i_wr_base(wr_base), .i_stall(stall), .o_rd_addr(rd_addr), .o_wr_addr(wr_addr),
        .o_issuing(issuing), .o_last_issue(last_issue), .o_pipe_busy(pipe_busy)
    );

    // vd entry matching the vs entry being read
    assign acc_addr = wr_base + (rd_addr - rd_base);

    // write data select; stream in and clear write at issue
    always_comb begin
        case (active_op)
            vec_pkg::OP_VSTREAMIN: begin
                vrf_wr_data = in_dout;
                vrf_we      = issuing && !stall;
                vrf_wr_addr = rd_addr;
            end
            vec_pkg::OP_VCLR: begin
                vrf_wr_data = '0;
                vrf_we      = issuing && !stall;
                vrf_wr_addr = rd_addr;
            end
            vec_pkg::OP_VMACC: begin
                vrf_wr_data = mac_sum;
                vrf_we      = mac_valid && !stall; // k+2 write back
                vrf_wr_addr = wr_addr;
            end
            default: begin
                vrf_wr_data = mac_sum;
                vrf_we      = 1'b0;
                vrf_wr_addr = wr_addr;
            end
        endcase
    end

    vec_regfile u_regfile (
        .clk(clk), .i_we(vrf_we), .i_wr_addr(vrf_wr_addr), .i_wr_data(vrf_wr_data),
        .i_rd_addr1(rd_addr), .i_rd_addr2(acc_addr), .i_rd_en(!stall),
        .o_rd_data1(rd_data1), .o_rd_data2(rd_data2)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s1_last  <= 1'b0;
            s2_last  <= 1'b0;
        end else if (!stall) begin
            s1_valid <= issuing;
            s1_last  <= last_issue;
            s2_last  <= s1_last;
        end
    end

    // stream word lines up with the read data
    always_ff @(posedge clk) begin
        if (!stall) begin
            in_q  <= in_dout;
            out_q <= rd_data1;
        end
    end

    mac_lanes u_mac (
        .clk(clk), .rst(rst), .i_en(!stall), .i_valid(s1_valid), .i_acc(rd_data2),
        .i_a(in_q), .i_b(rd_data1), .o_sum(mac_sum), .o_valid(mac_valid)
    );

    assign out_push = mac_valid && !stall && (active_op == vec_pkg::OP_VSTREAMOUT);
    assign out_din  = {s2_last, out_q};

    stream_fifo #(.WIDTH(PW + 1), .DEPTH(FIFO_DEPTH)) u_out_fifo (
        .clk(clk), .rst(rst), .i_push(out_push), .i_pop(i_m_tready && o_m_tvalid),
        .i_din(out_din), .o_dout(out_dout), .o_empty(out_empty), .o_full(out_full)
    );

    assign o_m_tvalid = !out_empty;
    assign o_m_tdata  = out_dout[PW-1:0];
    assign o_m_tlast  = out_dout[PW] && o_m_tvalid;
    assign o_m_tkeep  = {(PW/8){o_m_tvalid}};

endmodule

`default_nettype wire

//--- tb/vec_checker.sv
`timescale 1ns/1ps
`default_nettype none

module vec_checker #(
    parameter int ROWS = 1
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          i_done_loader,
    input  vec_pkg::opcode_e              i_instr_op,
    input  logic [vec_pkg::ADDR_W-1:0]    i_instr_vd,
    input  logic [vec_pkg::ADDR_W-1:0]    i_instr_vs,
    input  logic [vec_pkg::LEN_W-1:0]     i_instr_len,
    input  logic [vec_pkg::PHIT_W-1:0]    i_s_tdata,
    input  logic                          i_s_tvalid,
    input  logic                          i_s_tready,
    input  logic [vec_pkg::PHIT_W-1:0]    i_m_tdata,
    input  logic                          i_m_tvalid,
    input  logic                          i_m_tlast,
    input  logic [vec_pkg::PHIT_W/8-1:0]  i_m_tkeep,
    input  logic                          i_m_tready,
    input  logic                          i_done_steady,
    input  logic                          i_incr_pc,
    input  logic                          i_ap_done,
    input  logic                          i_final,
    output int                            o_errors
);

    localparam int PW = vec_pkg::PHIT_W;
    localparam int EW = vec_pkg::ELEM_W;

    logic [PW-1:0] regs [vec_pkg::VRF_DEPTH]; // register model
    logic [PW-1:0] in_q [$];                  // accepted stream-in beats
    logic [PW:0]   exp_q [$];                 // {tlast, tdata}
    logic [PW:0]   got_q [$];
    logic          was_rst = 1'b0;
    logic          prev_loader;
    logic          prev_steady;
    logic          prev_incr;
    logic          prev_end;
    int            rows_done;
    int            ap_pulses;

    task automatic flag_value(input string msg);
        o_errors++;
        $display("FAIL %0t: %s", $time, msg);
    endtask

    task automatic flag_event(input string msg);
        o_errors++;
        $display("error at %0t: %s", $time, msg);
    endtask

    // wrapping add of the low product bits in each lane
    function automatic logic [PW-1:0] lane_macc(input logic [PW-1:0] acc,
                                               input logic [PW-1:0] a,
                                               input logic [PW-1:0] b);
        logic [PW-1:0]   r;
        logic [2*EW-1:0] prod;
        for (int l = 0; l < vec_pkg::LANES; l++) begin
            prod = {32'b0, a[l*EW +: EW]} * {32'b0, b[l*EW +: EW]};
            r[l*EW +: EW] = acc[l*EW +: EW] + prod[EW-1:0];
        end
        return r;
    endfunction

    task automatic take_input(output logic [PW-1:0] s);
        if (in_q.size() == 0) begin
            flag_event("instruction finished without enough stream-in beats");
            s = 'x;
        end else begin
            s = in_q.pop_front();
        end
    endtask

    task automatic apply_instr();
        logic [vec_pkg::ADDR_W-1:0] off;
        logic [vec_pkg::ADDR_W-1:0] d;
        logic [vec_pkg::ADDR_W-1:0] v;
        logic [PW-1:0]              s;
        off = '0;
        for (int i = 0; i < int'(i_instr_len); i++) begin
            d = i_instr_vd + off; // entries wrap at the top of the file
            v = i_instr_vs + off;
            case (i_instr_op)
                vec_pkg::OP_VSTREAMIN: begin
                    take_input(s);
                    regs[d] = s;
                end
                vec_pkg::OP_VCLR: regs[d] = '0;
                vec_pkg::OP_VMACC: begin
                    take_input(s);
                    regs[d] = lane_macc(regs[d], s, regs[v]);
                end
                vec_pkg::OP_VSTREAMOUT: exp_q.push_back({i == int'(i_instr_len) - 1, regs[v]});
                default: ;
            endcase
            off = off + 1'b1;
        end
        if ((i_instr_op == vec_pkg::OP_VEND) != i_ap_done)
            flag_value("o_ap_done does not match the end instruction");
        $display("row %0d %s vd %0d vs %0d len %0d finished at %0t, errors %0d", rows_done,
                 i_instr_op.name(), i_instr_vd, i_instr_vs, i_instr_len, $time, o_errors);
        rows_done++;
    endtask

    task automatic final_check();
        if (exp_q.size() != 0 || got_q.size() != 0)
            flag_event($sformatf("stream out left %0d expected and %0d received beats unmatched",
                                 exp_q.size(), got_q.size()));
        if (in_q.size() != 0)
            flag_event($sformatf("%0d stream-in beats were never consumed", in_q.size()));
        if (rows_done != ROWS)
            flag_event($sformatf("saw %0d o_incr_pc pulses for %0d instructions", rows_done, ROWS));
        if (ap_pulses != 1)
            flag_event($sformatf("saw %0d o_ap_done pulses instead of one", ap_pulses));
    endtask

    always @(posedge clk) begin
        logic [PW:0] e;
        logic [PW:0] g;
        if (rst) begin
            was_rst     = 1'b1;
            prev_loader = 1'b0;
            prev_steady = 1'b0;
            prev_incr   = 1'b0;
            prev_end    = 1'b0;
            rows_done   = 0;
            ap_pulses   = 0;
            o_errors    = 0;
        end else begin
            if (was_rst && (i_s_tready || i_m_tvalid || i_done_steady || i_incr_pc || i_ap_done))
                flag_value("outputs not idle after reset");
            was_rst = 1'b0;
            if (!i_done_steady && (i_s_tready || i_incr_pc || i_ap_done))
                flag_value("activity while steady mode is off");
            if (i_done_steady && !prev_steady && !prev_loader)
                flag_event("steady mode entered without a loader strobe");
            if (prev_end && i_done_steady)
                flag_value("o_done_steady still high after the end instruction");

            if (i_s_tvalid && i_s_tready)
                in_q.push_back(i_s_tdata);
            if (i_m_tvalid && i_m_tready) begin
                if (i_m_tkeep != '1)
                    flag_value($sformatf("tkeep %h on a valid beat", i_m_tkeep));
                got_q.push_back({i_m_tlast, i_m_tdata});
            end

            if (i_incr_pc && prev_incr)
                flag_event("o_incr_pc held for more than one cycle");
            else if (i_incr_pc)
                apply_instr();
            if (i_ap_done)
                ap_pulses++; // every cycle counts, stray pulses included

            while (exp_q.size() > 0 && got_q.size() > 0) begin
                e = exp_q.pop_front();
                g = got_q.pop_front();
                if (g !== e)
                    flag_value($sformatf("beat %h last %b, expected %h last %b",
                                         g[PW-1:0], g[PW], e[PW-1:0], e[PW]));
            end

            prev_loader = i_done_loader;
            prev_steady = i_done_steady;
            prev_incr   = i_incr_pc;
            prev_end    = i_incr_pc && i_ap_done;
            if (i_final)
                final_check();
        end
    end

endmodule

`default_nettype wire

//--- tb/tb_vec_stream.sv
`timescale 1ns/1ps
`default_nettype none

module tb_vec_stream;

    localparam int PERIOD     = 40;
    localparam int FIFO_DEPTH = 4;  // shallow, so back-pressure reaches the sequencer
    localparam int NROWS      = 11;
    localparam int PW         = vec_pkg::PHIT_W;

    typedef struct packed {
        vec_pkg::opcode_e            op;
        logic [vec_pkg::ADDR_W-1:0]  vd;
        logic [vec_pkg::ADDR_W-1:0]  vs;
        logic [vec_pkg::LEN_W-1:0]   len;
        logic                        bp;  // random tready while the row runs
    } row_t;

    row_t rows [NROWS] = '{
        '{vec_pkg::OP_VSTREAMIN,  4'd0, 4'd0, 5'd8,  1'b0},
        '{vec_pkg::OP_VSTREAMOUT, 4'd0, 4'd0, 5'd8,  1'b0},  // echo of the first row
        '{vec_pkg::OP_VCLR,       4'd8, 4'd0, 5'd8,  1'b0},
        '{vec_pkg::OP_VMACC,      4'd8, 4'd0, 5'd8,  1'b0},
        '{vec_pkg::OP_VMACC,      4'd8, 4'd0, 5'd8,  1'b0},  // accumulates onto nonzero
        '{vec_pkg::OP_VSTREAMOUT, 4'd0, 4'd8, 5'd8,  1'b1},
        '{vec_pkg::OP_NOP,        4'd0, 4'd0, 5'd0,  1'b0},
        '{vec_pkg::OP_VSTREAMIN,  4'd0, 4'd0, 5'd4,  1'b0},
        '{vec_pkg::OP_VSTREAMOUT, 4'd0, 4'd0, 5'd16, 1'b1},  // whole file, stalls on full
        '{vec_pkg::OP_VSTREAMOUT, 4'd0, 4'd5, 5'd1,  1'b1},
        '{vec_pkg::OP_VEND,       4'd0, 4'd0, 5'd0,  1'b0}
    };

    logic                        clk = 1'b0;
    logic                        rst = 1'b1;
    logic                        done_loader = 1'b0;
    vec_pkg::opcode_e            instr_op = vec_pkg::OP_NOP;
    logic [vec_pkg::ADDR_W-1:0]  instr_vd = '0;
    logic [vec_pkg::ADDR_W-1:0]  instr_vs = '0;
    logic [vec_pkg::LEN_W-1:0]   instr_len = '0;
    logic [PW-1:0]               s_tdata = '0;
    logic                        s_tvalid = 1'b0;
    logic                        m_tready = 1'b1;
    logic                        s_tready, m_tvalid, m_tlast, done_steady, incr_pc, ap_done;
    logic [PW-1:0]               m_tdata;
    logic [PW/8-1:0]             m_tkeep;
    logic [31:0]                 data_rng = 32'h4cba;
    logic [31:0]                 ready_rng = 32'h4cba;
    logic                        cur_bp = 1'b0;
    logic                        check_end = 1'b0;
    int                          chk_errors;
    int                          hangs = 0;

    initial begin
        forever #(PERIOD/2) clk = ~clk;
    end

    vec_stream_top #(.FIFO_DEPTH(FIFO_DEPTH)) u_vec_stream_top (
        .clk(clk), .rst(rst), .i_done_loader(done_loader), .i_instr_op(instr_op),
        .i_instr_vd(instr_vd), .i_instr_vs(instr_vs), .i_instr_len(instr_len),
        .i_s_tdata(s_tdata), .i_s_tvalid(s_tvalid), .o_s_tready(s_tready),
        .o_m_tdata(m_tdata), .o_m_tvalid(m_tvalid), .o_m_tlast(m_tlast), .o_m_tkeep(m_tkeep),
        .i_m_tready(m_tready), .o_done_steady(done_steady), .o_incr_pc(incr_pc),
        .o_ap_done(ap_done)
    );

    vec_checker #(.ROWS(NROWS)) u_checker (
        .clk(clk), .rst(rst), .i_done_loader(done_loader), .i_instr_op(instr_op),
        .i_instr_vd(instr_vd), .i_instr_vs(instr_vs), .i_instr_len(instr_len),
        .i_s_tdata(s_tdata), .i_s_tvalid(s_tvalid), .i_s_tready(s_tready),
        .i_m_tdata(m_tdata), .i_m_tvalid(m_tvalid), .i_m_tlast(m_tlast), .i_m_tkeep(m_tkeep),
        .i_m_tready(m_tready), .i_done_steady(done_steady), .i_incr_pc(incr_pc),
        .i_ap_done(ap_done), .i_final(check_end), .o_errors(chk_errors)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic send_phits(input int n);
        logic [PW-1:0] p;
        for (int b = 0; b < n; b++) begin
            for (int l = 0; l < vec_pkg::LANES; l++) begin
                data_rng = xorshift32(data_rng);
                p[l*32 +: 32] = data_rng;
            end
            s_tdata  = p;
            s_tvalid = 1'b1;
            do @(posedge clk); while (!s_tready);
            #2;
        end
        s_tvalid = 1'b0;
    endtask

    // output sink, mode taken at the edge
    always @(posedge clk) begin
        logic bp_now;
        bp_now = cur_bp;
        #2;
        ready_rng = xorshift32(ready_rng);
        m_tready  = bp_now ? ready_rng[7] : 1'b1;
    end

    initial begin
        int limit;
        limit = 200;
        foreach (rows[r])
            limit += 100 * int'(rows[r].len);
        repeat (limit) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish", limit);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        int   waited;
        logic stuck;
        stuck = 1'b0;
        repeat (8) @(posedge clk);
        #2 rst = 1'b0;
        repeat (4) @(posedge clk); // idle, tready must stay low
        #2;
        for (int r = 0; r < NROWS && !stuck; r++) begin
            instr_op  = rows[r].op;
            instr_vd  = rows[r].vd;
            instr_vs  = rows[r].vs;
            instr_len = rows[r].len;
            cur_bp    = rows[r].bp;
            if (r == 0) begin
                done_loader = 1'b1;
                @(posedge clk);
                #2 done_loader = 1'b0;
            end
            if (rows[r].op == vec_pkg::OP_VSTREAMIN || rows[r].op == vec_pkg::OP_VMACC)
                send_phits(int'(rows[r].len));
            waited = 0;
            do begin
                @(posedge clk);
                waited++;
            end while (!incr_pc && waited < 100 * int'(rows[r].len) + 20);
            if (!incr_pc) begin
                $display("row %0d got no o_incr_pc pulse within %0d cycles", r, waited);
                hangs++;
                stuck = 1'b1;
            end
            #2;
        end
        cur_bp = 1'b0;
        waited = 0;
        while (m_tvalid && waited < 100) begin // let the output FIFO drain
            @(posedge clk);
            waited++;
        end
        repeat (2) @(posedge clk);
        #2 check_end = 1'b1;
        @(posedge clk);
        #2;
        $display("rows %0d, failed checks %0d, missing pulses %0d", NROWS, chk_errors, hangs);
        if (chk_errors == 0 && hangs == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
hdl/vec_pkg.sv
hdl/stream_fifo.sv
hdl/vec_regfile.sv
hdl/mac_lanes.sv
hdl/element_counter.sv
hdl/vec_sequencer.sv
hdl/vec_stream_top.sv
tb/vec_checker.sv
tb/tb_vec_stream.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_vec_stream
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= Result: PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
